//--- filelist.f
+incdir+verilog
verilog/fb_vga_pkg.sv
verilog/fb_pix_reader.sv
verilog/fb_pix_fifo.sv
verilog/vga_timing.sv
verilog/vga_pix_out.sv
verilog/fb_pix_vga.sv
tests/fb_mem_model.sv
tests/fb_pix_vga_tb.sv

//--- tests/fb_mem_model.sv
`include "fb_vga_defines.svh"

module fb_mem_model (
  input  logic                clk,
  input  logic                rst,
  input  logic                stall_all,
  input  logic                rd_req_valid,
  input  fb_vga_pkg::rd_req_t rd_req,
  output logic                rd_req_ready,
  input  logic                rd_rsp_ready,
  output logic                rd_rsp_valid,
  output fb_vga_pkg::rd_rsp_t rd_rsp
);
  timeunit 1ns;
  timeprecision 1ns;

  // Loaded by the testbench before each test
  logic [`FB_DATA_WIDTH-1:0] mem [0:(1 << `FB_ADDR_WIDTH)-1];

  // Accepted addresses waiting for their response, oldest first
  logic [`FB_ADDR_WIDTH-1:0] pending [$];
  logic                      hold;

  assign rd_req_ready = 1'b1;

  initial begin
    rd_rsp_valid = 1'b0;
    rd_rsp       = '0;
  end

  always @(posedge clk) begin
    if (rst) begin
      pending.delete();
      rd_rsp_valid <= 1'b0;
      rd_rsp       <= '0;
    end else begin
      if (rd_rsp_valid && rd_rsp_ready) begin
        void'(pending.pop_front());
      end
      if (rd_req_valid && rd_req_ready) begin
        pending.push_back(rd_req.addr);
      end
      // Random gap on one cycle in four
      hold = stall_all || (($urandom % 4) == 0);
      if ((pending.size() > 0) && !hold) begin
        rd_rsp_valid <= 1'b1;
        rd_rsp.data  <= mem[pending[0]];
      end else begin
        rd_rsp_valid <= 1'b0;
      end
    end
  end

endmodule

//--- tests/fb_pix_vga_tb.sv
`include "fb_vga_defines.svh"

module fb_pix_vga_tb;
  timeunit 1ns;
  timeprecision 1ns;

  localparam int NUM_ROWS     = 4;
  localparam int QUIET_CYCLES = 8;

  typedef enum logic [1:0] {
    PAT_STRIPES,
    PAT_GRADIENT,
    PAT_RANDOM
  } pat_kind_e;

  // Geometry, pattern, frames, stall window and expected error flag
  typedef struct packed {
    fb_vga_pkg::timing_t timing;
    pat_kind_e           kind;
    logic [7:0]          frames;
    logic [15:0]         stall_start;
    logic [15:0]         stall_len;
    logic                expect_err;
  } row_t;

  logic                clk = 1'b0;
  logic                rst;
  logic                stall_all;
  fb_vga_pkg::timing_t timing;
  logic                rd_req_ready;
  logic                rd_req_valid;
  fb_vga_pkg::rd_req_t rd_req;
  logic                rd_rsp_ready;
  logic                rd_rsp_valid;
  fb_vga_pkg::rd_rsp_t rd_rsp;
  fb_vga_pkg::vga_t    vga;
  logic                vga_error;

  row_t        rows [NUM_ROWS];
  logic [15:0] pat [0:65535];
  int          cycle_cnt = 0;
  int          cycle_limit = 0;

  // Scoreboard state
  int   de_n;
  int   req_n;
  int   line_de;
  int   hs_low;
  int   vs_lines;
  int   frames_done;
  logic prev_de;
  logic prev_hs;
  logic prev_vs;

  fb_pix_vga u_dut (
    .clk         (clk),
    .rst         (rst),
    .timing      (timing),
    .rd_req_ready(rd_req_ready),
    .rd_rsp_valid(rd_rsp_valid),
    .rd_rsp      (rd_rsp),
    .rd_req_valid(rd_req_valid),
    .rd_req      (rd_req),
    .rd_rsp_ready(rd_rsp_ready),
    .vga         (vga),
    .vga_error   (vga_error)
  );

  fb_mem_model u_mem (
    .clk         (clk),
    .rst         (rst),
    .stall_all   (stall_all),
    .rd_req_valid(rd_req_valid),
    .rd_req      (rd_req),
    .rd_req_ready(rd_req_ready),
    .rd_rsp_ready(rd_rsp_ready),
    .rd_rsp_valid(rd_rsp_valid),
    .rd_rsp      (rd_rsp)
  );

  always #20 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if ((cycle_limit > 0) && (cycle_cnt >= cycle_limit)) begin
      abort_run($sformatf("timeout: the tests did not finish within %0d cycles", cycle_limit));
    end
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Errors found");
    $fatal(1, "run stopped at the first failure");
  endtask

  task automatic check_rgb(input string name, input fb_vga_pkg::rgb_t got,
                           input fb_vga_pkg::rgb_t exp);
    if (got !== exp) begin
      abort_run($sformatf("error: %s got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      abort_run($sformatf("error: %s got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) begin
      abort_run($sformatf("error: %s got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_req(input string name, input fb_vga_pkg::rd_req_t got,
                           input fb_vga_pkg::rd_req_t exp);
    if (got !== exp) begin
      abort_run($sformatf("error: %s got %h expected %h", name, got, exp));
    end
  endtask

  function automatic fb_vga_pkg::timing_t make_timing(int hv, int hss, int hse, int hle,
                                                     int vv, int vss, int vse, int vfe);
    fb_vga_pkg::timing_t t;
    t.h_visible    = hv;
    t.h_sync_start = hss;
    t.h_sync_end   = hse;
    t.h_line_end   = hle;
    t.v_visible    = vv;
    t.v_sync_start = vss;
    t.v_sync_end   = vse;
    t.v_frame_end  = vfe;
    return t;
  endfunction

  // Top nibble is unused by the display
  function automatic logic [15:0] pattern_word(pat_kind_e kind, int x, int y);
    logic [15:0] w;
    case (kind)
      PAT_STRIPES:  w = {4'hC, {4{x[1]}}, 4'(y), 4'(x >> 2)};
      PAT_GRADIENT: w = {4'h3, 4'(x), 4'(y), 4'(x + y)};
      default:      w = 16'($urandom);
    endcase
    return w;
  endfunction

  task automatic fill_pattern(input row_t r);
    int hv;
    int a;
    logic [15:0] w;
    hv = int'(r.timing.h_visible);
    for (int y = 0; y < int'(r.timing.v_visible); y++) begin
      for (int x = 0; x < hv; x++) begin
        a = y * hv + x;
        w = pattern_word(r.kind, x, y);
        pat[a] = w;
        u_mem.mem[a] = w;
      end
    end
  endtask

  task automatic check_idle_outputs();
    check_bit("vga.de", vga.de, 1'b0);
    check_rgb("vga.rgb", vga.rgb, '0);
    check_bit("vga.hsync", vga.hsync, 1'b1);
    check_bit("vga.vsync", vga.vsync, 1'b1);
    check_bit("vga_error", vga_error, 1'b0);
  endtask

  task automatic apply_reset(input row_t r);
    @(posedge clk);
    rst       <= 1'b1;
    timing    <= r.timing;
    stall_all <= 1'b0;
    fill_pattern(r);
    @(posedge clk);
    @(negedge clk);
    check_idle_outputs();
    check_bit("rd_req_valid", rd_req_valid, 1'b0);
    @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    check_idle_outputs();
    check_bit("rd_req_valid", rd_req_valid, 1'b0);
  endtask

  task automatic watch_outputs(input row_t r, input int cyc);
    int hv;
    int px;
    int py;
    fb_vga_pkg::rgb_t exp_rgb;
    fb_vga_pkg::rd_req_t exp_req;
    hv = int'(r.timing.h_visible);
    // Counters are frozen until the FIFO is prefilled
    if (cyc < QUIET_CYCLES) begin
      check_idle_outputs();
    end
    // Requests walk the frame in raster order and wrap to word 0
    check_bit("rd_rsp_ready", rd_rsp_ready, 1'b1);
    if (rd_req_valid && rd_req_ready) begin
      exp_req.addr = req_n;
      check_req("rd_req.addr", rd_req, exp_req);
      req_n = (req_n + 1) % (hv * int'(r.timing.v_visible));
    end
    if (!r.expect_err || (cyc < r.stall_start)) begin
      check_bit("vga_error", vga_error, 1'b0);
    end else if (cyc >= r.stall_start + r.stall_len - 1) begin
      check_bit("vga_error", vga_error, 1'b1);
    end
    if (vga.de) begin
      if (!r.expect_err || (cyc < r.stall_start)) begin
        px = de_n % hv;
        py = de_n / hv;
        exp_rgb = pat[py * hv + px][11:0];
        check_rgb("vga.rgb", vga.rgb, exp_rgb);
      end
      de_n++;
      line_de++;
    end else begin
      check_rgb("vga.rgb", vga.rgb, '0);
      if (prev_de) begin
        check_count("line de cycles", line_de, hv);
        line_de = 0;
      end
    end
    if (!vga.hsync) begin
      hs_low++;
      if (prev_hs && !vga.vsync) begin
        vs_lines++;
      end
    end else if (!prev_hs) begin
      check_count("hsync low cycles", hs_low, r.timing.h_sync_end - r.timing.h_sync_start);
      hs_low = 0;
    end
    if (!vga.vsync && prev_vs) begin
      check_count("frame de cycles", de_n, hv * int'(r.timing.v_visible));
      de_n = 0;
    end else if (vga.vsync && !prev_vs) begin
      check_count("vsync low lines", vs_lines, r.timing.v_sync_end - r.timing.v_sync_start);
      vs_lines = 0;
      frames_done++;
    end
    prev_de = vga.de;
    prev_hs = vga.hsync;
    prev_vs = vga.vsync;
  endtask

  // Ends on the vsync rising edge of the last frame
  task automatic run_row(input row_t r);
    int cyc;
    cyc = 0;
    de_n = 0;
    req_n = 0;
    line_de = 0;
    hs_low = 0;
    vs_lines = 0;
    frames_done = 0;
    prev_de = 1'b0;
    prev_hs = 1'b1;
    prev_vs = 1'b1;
    while (frames_done < int'(r.frames)) begin
      @(posedge clk);
      stall_all <= (r.stall_len != 0) && (cyc >= r.stall_start) &&
                   (cyc < r.stall_start + r.stall_len);
      @(negedge clk);
      watch_outputs(r, cyc);
      cyc++;
    end
  endtask

  initial begin
    int seed_ret;
    rst       = 1'b1;
    stall_all = 1'b0;
    timing    = '0;
    seed_ret  = $urandom(32'h568448e5);

    rows[0] = {make_timing(8, 10, 12, 16, 4, 5, 6, 8), PAT_STRIPES, 8'd3, 16'd0, 16'd0, 1'b0};
    rows[1] = {make_timing(8, 10, 12, 16, 4, 5, 6, 8), PAT_GRADIENT, 8'd2, 16'd0, 16'd0, 1'b0};
    // Long stall_all over visible lines of the first frame
    rows[2] = {make_timing(8, 10, 12, 16, 4, 5, 6, 8), PAT_RANDOM, 8'd2, 16'd40, 16'd60, 1'b1};
    rows[3] = {make_timing(6, 7, 9, 12, 3, 4, 5, 6), PAT_RANDOM, 8'd3, 16'd0, 16'd0, 1'b0};

    for (int i = 0; i < NUM_ROWS; i++) begin
      cycle_limit += int'(rows[i].frames) * int'(rows[i].timing.h_line_end) *
                     int'(rows[i].timing.v_frame_end) + 200;
    end

    for (int i = 0; i < NUM_ROWS; i++) begin
      apply_reset(rows[i]);
      run_row(rows[i]);
    end

    $display("No errors");
    $finish;
  end

endmodule

//--- verilog/fb_pix_fifo.sv
`include "fb_vga_defines.svh"

module fb_pix_fifo (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   push,
  input  fb_vga_pkg::pix_t       push_data,
  input  logic                   pop,
  output fb_vga_pkg::pix_t       head,
  output logic                   empty,
  output logic [`FB_FIFO_LOG2:0] level
);

  fb_vga_pkg::pix_t mem [`FB_FIFO_DEPTH];

  logic [`FB_FIFO_LOG2-1:0] wr_ptr;
  logic [`FB_FIFO_LOG2-1:0] rd_ptr;
  logic [`FB_FIFO_LOG2:0]   count;
  logic                     do_pop;

  // Popping an empty FIFO is ignored
  assign do_pop = pop && !empty;

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end

      case ({push, do_pop})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Oldest entry is always visible
  assign head  = mem[rd_ptr];
  assign empty = (count == '0);
  assign level = count;

endmodule

//--- verilog/fb_pix_reader.sv
`include "fb_vga_defines.svh"

module fb_pix_reader (
  input  logic                  clk,
  input  logic                  rst,
  input  fb_vga_pkg::timing_t   timing,
  input  logic                  rd_req_ready,
  input  logic                  rd_rsp_valid,
  input  fb_vga_pkg::rd_rsp_t   rd_rsp,
  input  logic [`FB_FIFO_LOG2:0] level,
  output logic                  rd_req_valid,
  output fb_vga_pkg::rd_req_t   rd_req,
  output logic                  rd_rsp_ready,
  output logic                  push,
  output fb_vga_pkg::pix_t      push_data
);

  fb_vga_pkg::reader_state_e state;

  // Raster position and word address of the next request
  logic [`FB_H_WIDTH-1:0]    x;
  logic [`FB_V_WIDTH-1:0]    y;
  logic [`FB_ADDR_WIDTH-1:0] addr;

  // Coordinates of requests still waiting for data, oldest at q_rd
  logic [`FB_H_WIDTH-1:0]    q_x [`FB_FIFO_DEPTH];
  logic [`FB_V_WIDTH-1:0]    q_y [`FB_FIFO_DEPTH];
  logic [`FB_FIFO_LOG2:0]    q_wr;
  logic [`FB_FIFO_LOG2:0]    q_rd;
  logic [`FB_FIFO_LOG2:0]    in_flight;
  logic [`FB_FIFO_LOG2+1:0]  budget;

  logic credit;
  logic req_fire;
  logic last_col;
  logic last_row;

  assign in_flight = q_wr - q_rd;

  // Space in the FIFO is claimed at request time
  assign budget = in_flight + level;
  assign credit = budget < (`FB_FIFO_LOG2 + 2)'(`FB_FIFO_DEPTH);

  assign rd_req_valid = (state == fb_vga_pkg::FETCH) && credit;
  assign rd_req.addr  = addr;
  assign req_fire     = rd_req_valid && rd_req_ready;

  assign last_col = (x == timing.h_visible - 1'b1);
  assign last_row = (y == timing.v_visible - 1'b1);

  // Never back-pressure responses
  assign rd_rsp_ready = 1'b1;
  assign push         = rd_rsp_valid && rd_rsp_ready;

  assign push_data.rgb = rd_rsp.data[3*`FB_COLOR_WIDTH-1:0];
  assign push_data.x   = q_x[q_rd[`FB_FIFO_LOG2-1:0]];
  assign push_data.y   = q_y[q_rd[`FB_FIFO_LOG2-1:0]];

  always_ff @(posedge clk) begin
    if (req_fire) begin
      q_x[q_wr[`FB_FIFO_LOG2-1:0]] <= x;
      q_y[q_wr[`FB_FIFO_LOG2-1:0]] <= y;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= fb_vga_pkg::IDLE;
      x     <= '0;
      y     <= '0;
      addr  <= '0;
      q_wr  <= '0;
      q_rd  <= '0;
    end else begin
      if (req_fire) begin
        q_wr <= q_wr + 1'b1;
      end
      if (push) begin
        q_rd <= q_rd + 1'b1;
      end

      case (state)
        fb_vga_pkg::IDLE: begin
          state <= fb_vga_pkg::FETCH;
        end
        fb_vga_pkg::FETCH: begin
          if (req_fire) begin
            addr <= addr + 1'b1;
            if (last_col) begin
              x <= '0;
              // Frame done after the bottom right pixel
              if (last_row) begin
                state <= fb_vga_pkg::WRAP;
              end else begin
                y <= y + 1'b1;
              end
            end else begin
              x <= x + 1'b1;
            end
          end
        end
        fb_vga_pkg::WRAP: begin
          x     <= '0;
          y     <= '0;
          addr  <= '0;
          state <= fb_vga_pkg::FETCH;
        end
        default: begin
          state <= fb_vga_pkg::IDLE;
        end
      endcase
    end
  end

endmodule

//--- verilog/fb_pix_vga.sv
`include "fb_vga_defines.svh"

module fb_pix_vga (
  input  logic                clk,
  input  logic                rst,
  input  fb_vga_pkg::timing_t timing,
  input  logic                rd_req_ready,
  input  logic                rd_rsp_valid,
  input  fb_vga_pkg::rd_rsp_t rd_rsp,
  output logic                rd_req_valid,
  output fb_vga_pkg::rd_req_t rd_req,
  output logic                rd_rsp_ready,
  output fb_vga_pkg::vga_t    vga,
  output logic                vga_error
);

  // Reader to FIFO
  logic                   push;
  fb_vga_pkg::pix_t       push_data;
  logic [`FB_FIFO_LOG2:0] level;

  // FIFO to output stage
  fb_vga_pkg::pix_t       head;
  logic                   empty;
  logic                   pop;

  // Scan position and syncs
  logic                   start;
  logic [`FB_H_WIDTH-1:0] x;
  logic [`FB_V_WIDTH-1:0] y;
  logic                   visible;
  logic                   hsync_n;
  logic                   vsync_n;

  fb_pix_reader u_reader (
    .clk         (clk),
    .rst         (rst),
    .timing      (timing),
    .rd_req_ready(rd_req_ready),
    .rd_rsp_valid(rd_rsp_valid),
    .rd_rsp      (rd_rsp),
    .level       (level),
    .rd_req_valid(rd_req_valid),
    .rd_req      (rd_req),
    .rd_rsp_ready(rd_rsp_ready),
    .push        (push),
    .push_data   (push_data)
  );

  fb_pix_fifo u_fifo (
    .clk      (clk),
    .rst      (rst),
    .push     (push),
    .push_data(push_data),
    .pop      (pop),
    .head     (head),
    .empty    (empty),
    .level    (level)
  );

  vga_timing u_timing (
    .clk    (clk),
    .rst    (rst),
    .timing (timing),
    .start  (start),
    .x      (x),
    .y      (y),
    .visible(visible),
    .hsync_n(hsync_n),
    .vsync_n(vsync_n)
  );

  vga_pix_out u_pix_out (
    .clk      (clk),
    .rst      (rst),
    .head     (head),
    .empty    (empty),
    .level    (level),
    .x        (x),
    .y        (y),
    .visible  (visible),
    .hsync_n  (hsync_n),
    .vsync_n  (vsync_n),
    .pop      (pop),
    .start    (start),
    .vga      (vga),
    .vga_error(vga_error)
  );

endmodule

//--- verilog/fb_vga_defines.svh
`ifndef FB_VGA_DEFINES_SVH
`define FB_VGA_DEFINES_SVH

// Scan counter widths
`define FB_H_WIDTH 12
`define FB_V_WIDTH 12

// Bits per colour channel
`define FB_COLOR_WIDTH 4

// Memory read channel
`define FB_ADDR_WIDTH 16
`define FB_DATA_WIDTH 16

// Pixel FIFO, also bounds the reader's requests in flight
`define FB_FIFO_LOG2 3
`define FB_FIFO_DEPTH (1 << `FB_FIFO_LOG2)

`endif

//--- verilog/fb_vga_pkg.sv
`include "fb_vga_defines.svh"

package fb_vga_pkg;

  typedef struct packed {
    logic [`FB_COLOR_WIDTH-1:0] red;
    logic [`FB_COLOR_WIDTH-1:0] grn;
    logic [`FB_COLOR_WIDTH-1:0] blu;
  } rgb_t;

  // Video geometry, all values in pixels or lines
  typedef struct packed {
    logic [`FB_H_WIDTH-1:0] h_visible;
    logic [`FB_H_WIDTH-1:0] h_sync_start;
    logic [`FB_H_WIDTH-1:0] h_sync_end;
    logic [`FB_H_WIDTH-1:0] h_line_end;
    logic [`FB_V_WIDTH-1:0] v_visible;
    logic [`FB_V_WIDTH-1:0] v_sync_start;
    logic [`FB_V_WIDTH-1:0] v_sync_end;
    logic [`FB_V_WIDTH-1:0] v_frame_end;
  } timing_t;

  typedef struct packed {
    logic [`FB_ADDR_WIDTH-1:0] addr;
  } rd_req_t;

  typedef struct packed {
    logic [`FB_DATA_WIDTH-1:0] data;
  } rd_rsp_t;

  // Fetched pixel tagged with its frame position
  typedef struct packed {
    rgb_t                   rgb;
    logic [`FB_H_WIDTH-1:0] x;
    logic [`FB_V_WIDTH-1:0] y;
  } pix_t;

  // Syncs are active low
  typedef struct packed {
    rgb_t rgb;
    logic hsync;
    logic vsync;
    logic de;
  } vga_t;

  typedef enum logic [1:0] {
    IDLE,
    FETCH,
    WRAP
  } reader_state_e;

endpackage

//--- verilog/vga_pix_out.sv
`include "fb_vga_defines.svh"

module vga_pix_out (
  input  logic                   clk,
  input  logic                   rst,
  input  fb_vga_pkg::pix_t       head,
  input  logic                   empty,
  input  logic [`FB_FIFO_LOG2:0] level,
  input  logic [`FB_H_WIDTH-1:0] x,
  input  logic [`FB_V_WIDTH-1:0] y,
  input  logic                   visible,
  input  logic                   hsync_n,
  input  logic                   vsync_n,
  output logic                   pop,
  output logic                   start,
  output fb_vga_pkg::vga_t       vga,
  output logic                   vga_error
);

  logic full;
  logic underflow;
  logic mismatch;

  assign full = (level == (`FB_FIFO_LOG2 + 1)'(`FB_FIFO_DEPTH));

  // One pixel per visible cycle
  assign pop = visible && !empty;

  assign underflow = visible && empty;

  // Fetched pixel must belong to the current scan position
  assign mismatch = pop && ((head.x != x) || (head.y != y));

  always_ff @(posedge clk) begin
    if (rst) begin
      start <= 1'b0;
    end else if (full) begin
      start <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      vga.rgb   <= '0;
      vga.hsync <= 1'b1;
      vga.vsync <= 1'b1;
      vga.de    <= 1'b0;
    end else begin
      vga.de    <= visible;
      vga.hsync <= hsync_n;
      vga.vsync <= vsync_n;
      // Black in blanking and on underflow
      if (pop) begin
        vga.rgb <= head.rgb;
      end else begin
        vga.rgb <= '0;
      end
    end
  end

  // Sticky until reset
  always_ff @(posedge clk) begin
    if (rst) begin
      vga_error <= 1'b0;
    end else if (underflow || mismatch) begin
      vga_error <= 1'b1;
    end
  end

endmodule

//--- verilog/vga_timing.sv
`include "fb_vga_defines.svh"

module vga_timing (
  input  logic                   clk,
  input  logic                   rst,
  input  fb_vga_pkg::timing_t    timing,
  input  logic                   start,
  output logic [`FB_H_WIDTH-1:0] x,
  output logic [`FB_V_WIDTH-1:0] y,
  output logic                   visible,
  output logic                   hsync_n,
  output logic                   vsync_n
);

  logic [`FB_H_WIDTH-1:0] h_cnt;
  logic [`FB_V_WIDTH-1:0] v_cnt;
  logic                   last_h;
  logic                   last_v;
  logic                   h_active;
  logic                   v_active;
  logic                   h_in_sync;
  logic                   v_in_sync;

  assign last_h = (h_cnt == timing.h_line_end - 1'b1);
  assign last_v = (v_cnt == timing.v_frame_end - 1'b1);

  // Counters sit at the origin until the FIFO has been prefilled
  always_ff @(posedge clk) begin
    if (rst) begin
      h_cnt <= '0;
      v_cnt <= '0;
    end else if (start) begin
      if (last_h) begin
        h_cnt <= '0;
        if (last_v) begin
          v_cnt <= '0;
        end else begin
          v_cnt <= v_cnt + 1'b1;
        end
      end else begin
        h_cnt <= h_cnt + 1'b1;
      end
    end
  end

  assign h_active = (h_cnt < timing.h_visible);
  assign v_active = (v_cnt < timing.v_visible);

  assign h_in_sync = (h_cnt >= timing.h_sync_start) && (h_cnt < timing.h_sync_end);
  assign v_in_sync = (v_cnt >= timing.v_sync_start) && (v_cnt < timing.v_sync_end);

  // Origin is not shown before start
  assign visible = start && h_active && v_active;
  assign hsync_n = !h_in_sync;
  assign vsync_n = !v_in_sync;

  assign x = h_cnt;
  assign y = v_cnt;

endmodule
